// File: common/wwc_pkg.sv
/*
  Shared widths and types for the 32 to 64 bit write width converter.
  The master word must be exactly two slave beats wide.
  Slave addresses are taken as 8-byte aligned after clearing ALIGN_BITS.
*/

package wwc_pkg;

    // ----------------------------------------------------------
    // widths
    // ----------------------------------------------------------

    localparam int ADDR_W     = 32;
    localparam int S_DATA_W   = 32;
    localparam int M_DATA_W   = 64;
    localparam int S_STRB_W   = S_DATA_W / 8;
    localparam int M_STRB_W   = M_DATA_W / 8;

    // low address bits dropped when aligning to the master word
    localparam int ALIGN_BITS = 3;

    // ----------------------------------------------------------
    // length limits
    // ----------------------------------------------------------

    // awlen holds beat count minus one
    localparam int LEN_W            = 8;
    localparam int BURST_FIFO_DEPTH = 4;

    // ----------------------------------------------------------
    // types
    // ----------------------------------------------------------

    typedef logic [S_DATA_W-1:0] s_word_t;
    typedef logic [LEN_W-1:0]    len_t;

    // master word, seen whole or as two slave lanes
    // lane 0 sits in the low half
    typedef union packed {
        logic [M_DATA_W-1:0] flat;
        s_word_t [1:0]       lane;
    } m_word_u;

endpackage

// File: gate/burst_fifo.sv
/*
  Small register-array FIFO of burst master lengths.
  DEPTH must be a power of two, 2 or more. Push when full and pop when
  empty are ignored. A pushed entry shows at the head one cycle later.
*/

`timescale 1ns/1ps

module burst_fifo import wwc_pkg::*; #(
    parameter int DEPTH = BURST_FIFO_DEPTH
) (
    input  logic aclk,
    input  logic rst_n,

    input  logic push,
    input  len_t push_len,
    input  logic pop,

    output logic full,
    output logic empty,
    output len_t head_len
);

    localparam int PTR_W = $clog2(DEPTH);

    len_t             mem [DEPTH];
    logic [PTR_W:0]   wr_ptr;
    logic [PTR_W:0]   rd_ptr;

    // wrap bit tells full from empty
    assign empty    = (wr_ptr == rd_ptr);
    assign full     = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                      (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
    assign head_len = mem[rd_ptr[PTR_W-1:0]];

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push && !full) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop && !empty) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (push && !full) begin
            mem[wr_ptr[PTR_W-1:0]] <= push_len;
        end
    end

endmodule

// File: gate/w_burst_gate.sv
/*
  Burst gate. Packed words pass only while a burst record sits at the
  queue head, with no added latency. A beat counter against the head
  length drives m_wlast; the record is popped on the last transfer.
*/

`timescale 1ns/1ps

module w_burst_gate import wwc_pkg::*; (
    input  logic                aclk,
    input  logic                rst_n,

    input  len_t                rec_len,
    input  logic                rec_valid,
    output logic                rec_ready,

    input  m_word_u             pk_data,
    input  logic [M_STRB_W-1:0] pk_strb,
    input  logic                pk_valid,
    output logic                pk_ready,

    output logic [M_DATA_W-1:0] m_wdata,
    output logic [M_STRB_W-1:0] m_wstrb,
    output logic                m_wlast,
    output logic                m_wvalid,
    input  logic                m_wready
);

    logic fifo_full;
    logic fifo_empty;
    logic has_rec;
    logic beat_xfer;
    len_t head_len;
    len_t beat_cnt;

    burst_fifo u_burst_fifo (
        .aclk     (aclk),
        .rst_n    (rst_n),
        .push     (rec_valid),
        .push_len (rec_len),
        .pop      (beat_xfer && m_wlast),
        .full     (fifo_full),
        .empty    (fifo_empty),
        .head_len (head_len)
    );

    assign rec_ready = !fifo_full;
    assign has_rec   = !fifo_empty;

    // ----------------------------------------------------------
    // data pass
    // ----------------------------------------------------------

    assign m_wvalid  = pk_valid && has_rec;
    assign pk_ready  = m_wready && has_rec;
    assign m_wdata   = pk_data.flat;
    assign m_wstrb   = pk_strb;
    assign beat_xfer = m_wvalid && m_wready;

    // last beat when the count reaches the head's awlen
    assign m_wlast = has_rec && (beat_cnt == head_len);

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            beat_cnt <= '0;
        end else if (beat_xfer) begin
            if (m_wlast) begin
                beat_cnt <= '0;
            end else begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

endmodule

// File: wpack/w_pack.sv
/*
  Packs pairs of 32-bit beats into one 64-bit word held in a single register.
  endian picks the lane of the first beat. A burst ending on a half word is
  flushed with the empty lane zeroed and its strobes cleared.
*/

`timescale 1ns/1ps

module w_pack import wwc_pkg::*; (
    input  logic                aclk,
    input  logic                rst_n,
    input  logic                endian,

    input  s_word_t             s_wdata,
    input  logic                s_wlast,
    input  logic                s_wvalid,
    output logic                s_wready,

    output m_word_u             pk_data,
    output logic [M_STRB_W-1:0] pk_strb,
    output logic                pk_valid,
    input  logic                pk_ready
);

    logic                run;
    logic                half;
    logic                lane_sel;
    logic                beat_acc;
    logic                word_done;
    m_word_u             word_nxt;
    logic [M_STRB_W-1:0] strb_nxt;

    // lane pointer, first beat goes to lane endian
    assign lane_sel = endian ^ half;

    // no new beat while a finished word waits
    assign s_wready  = run && (!pk_valid || pk_ready);
    assign beat_acc  = s_wvalid && s_wready;
    assign word_done = half || s_wlast;

    // ----------------------------------------------------------
    // next word
    // ----------------------------------------------------------

    always_comb begin
        // a fresh word starts from zeros
        word_nxt = half ? pk_data : '0;
        strb_nxt = half ? pk_strb : '0;
        word_nxt.lane[lane_sel] = s_wdata;
        strb_nxt[lane_sel*S_STRB_W +: S_STRB_W] = '1;
    end

    // ----------------------------------------------------------
    // control
    // ----------------------------------------------------------

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            run      <= 1'b0;
            half     <= 1'b0;
            pk_valid <= 1'b0;
        end else begin
            run <= 1'b1;
            if (pk_valid && pk_ready) begin
                pk_valid <= 1'b0;
            end
            if (beat_acc) begin
                // pointer restarts after every word and every s_wlast
                half <= !word_done;
                if (word_done) begin
                    pk_valid <= 1'b1;
                end
            end
        end
    end

    // packing register
    always_ff @(posedge aclk) begin
        if (beat_acc) begin
            pk_data <= word_nxt;
            pk_strb <= strb_nxt;
        end
    end

endmodule

// File: hdl/aw_convert.sv
/*
  Write command path. Aligns the address to 8 bytes and halves the length.
  Holds one command in its output register; a burst record for the gate is
  pushed on the same cycle the slave command is accepted.
*/

`timescale 1ns/1ps

module aw_convert import wwc_pkg::*; (
    input  logic              aclk,
    input  logic              rst_n,

    input  logic [ADDR_W-1:0] s_awaddr,
    input  len_t              s_awlen,
    input  logic              s_awvalid,
    output logic              s_awready,

    output logic [ADDR_W-1:0] m_awaddr,
    output len_t              m_awlen,
    output logic              m_awvalid,
    input  logic              m_awready,

    output len_t              rec_len,
    output logic              rec_valid,
    input  logic              rec_ready
);

    logic              run;
    logic              out_free;
    logic              cmd_acc;
    logic [ADDR_W-1:0] addr_aligned;
    len_t              len_conv;

    // output register empty or draining this cycle
    assign out_free = !m_awvalid || m_awready;

    assign addr_aligned = {s_awaddr[ADDR_W-1:ALIGN_BITS], {ALIGN_BITS{1'b0}}};

    // two slave beats per master beat, odd count rounds up
    assign len_conv = s_awlen >> 1;

    assign rec_len   = len_conv;
    assign rec_valid = run && s_awvalid && out_free;
    assign s_awready = run && out_free && rec_ready;
    assign cmd_acc   = rec_valid && rec_ready;

    // ----------------------------------------------------------
    // control
    // ----------------------------------------------------------

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            run       <= 1'b0;
            m_awvalid <= 1'b0;
        end else begin
            run <= 1'b1;
            if (cmd_acc) begin
                m_awvalid <= 1'b1;
            end else if (m_awready) begin
                m_awvalid <= 1'b0;
            end
        end
    end

    // payload
    always_ff @(posedge aclk) begin
        if (cmd_acc) begin
            m_awaddr <= addr_aligned;
            m_awlen  <= len_conv;
        end
    end

endmodule

// File: hdl/axi4_write_width_convert.sv
/*
  AXI4-style write width converter, 32-bit slave to 64-bit master.
  Single clock. Slave addresses should be 8-byte aligned, stray low bits
  are dropped. Slave strobes are taken as all ones. endian must only
  change while the converter is idle.
*/

`timescale 1ns/1ps

module axi4_write_width_convert import wwc_pkg::*; (
    input  logic                aclk,
    input  logic                rst_n,
    input  logic                endian,

    input  logic [ADDR_W-1:0]   s_awaddr,
    input  len_t                s_awlen,
    input  logic                s_awvalid,
    output logic                s_awready,

    output logic [ADDR_W-1:0]   m_awaddr,
    output len_t                m_awlen,
    output logic                m_awvalid,
    input  logic                m_awready,

    input  s_word_t             s_wdata,
    input  logic                s_wlast,
    input  logic                s_wvalid,
    output logic                s_wready,

    output logic [M_DATA_W-1:0] m_wdata,
    output logic [M_STRB_W-1:0] m_wstrb,
    output logic                m_wlast,
    output logic                m_wvalid,
    input  logic                m_wready
);

    // burst records, command path to gate
    len_t                rec_len;
    logic                rec_valid;
    logic                rec_ready;

    // packed words, data path to gate
    m_word_u             pk_data;
    logic [M_STRB_W-1:0] pk_strb;
    logic                pk_valid;
    logic                pk_ready;

    aw_convert u_aw_convert (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .s_awaddr  (s_awaddr),
        .s_awlen   (s_awlen),
        .s_awvalid (s_awvalid),
        .s_awready (s_awready),
        .m_awaddr  (m_awaddr),
        .m_awlen   (m_awlen),
        .m_awvalid (m_awvalid),
        .m_awready (m_awready),
        .rec_len   (rec_len),
        .rec_valid (rec_valid),
        .rec_ready (rec_ready)
    );

    w_pack u_w_pack (
        .aclk     (aclk),
        .rst_n    (rst_n),
        .endian   (endian),
        .s_wdata  (s_wdata),
        .s_wlast  (s_wlast),
        .s_wvalid (s_wvalid),
        .s_wready (s_wready),
        .pk_data  (pk_data),
        .pk_strb  (pk_strb),
        .pk_valid (pk_valid),
        .pk_ready (pk_ready)
    );

    w_burst_gate u_w_burst_gate (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .rec_len   (rec_len),
        .rec_valid (rec_valid),
        .rec_ready (rec_ready),
        .pk_data   (pk_data),
        .pk_strb   (pk_strb),
        .pk_valid  (pk_valid),
        .pk_ready  (pk_ready),
        .m_wdata   (m_wdata),
        .m_wstrb   (m_wstrb),
        .m_wlast   (m_wlast),
        .m_wvalid  (m_wvalid),
        .m_wready  (m_wready)
    );

endmodule

// File: sim/wwc_props.sv
/*
  Bound checks on master handshake stability, command alignment and the
  state right after reset. err_seen goes high on the first failed property.
*/

`timescale 1ns/1ps

module wwc_props import wwc_pkg::*; (
    input logic                aclk,
    input logic                rst_n,
    input logic                s_awready,
    input logic                s_wready,
    input logic [ADDR_W-1:0]   m_awaddr,
    input len_t                m_awlen,
    input logic                m_awvalid,
    input logic                m_awready,
    input logic [M_DATA_W-1:0] m_wdata,
    input logic [M_STRB_W-1:0] m_wstrb,
    input logic                m_wlast,
    input logic                m_wvalid,
    input logic                m_wready
);

    logic err_seen;

    initial err_seen = 1'b0;

    // stalled command keeps valid and payload
    aw_hold: assert property (@(posedge aclk) disable iff (!rst_n)
        m_awvalid && !m_awready |=> m_awvalid && $stable(m_awaddr) && $stable(m_awlen))
    else begin
        err_seen = 1'b1;
        $error("m_aw valid or payload changed while stalled");
    end

    // stalled data word keeps valid, data, strobes and last
    w_hold: assert property (@(posedge aclk) disable iff (!rst_n)
        m_wvalid && !m_wready |=> m_wvalid && $stable(m_wdata) && $stable(m_wstrb)
            && $stable(m_wlast))
    else begin
        err_seen = 1'b1;
        $error("m_w valid or payload changed while stalled");
    end

    reset_quiet: assert property (@(posedge aclk)
        $rose(rst_n) |-> !s_awready && !s_wready && !m_awvalid && !m_wvalid && !m_wlast)
    else begin
        err_seen = 1'b1;
        $error("handshake outputs not low in the first cycle after reset");
    end

    aw_aligned: assert property (@(posedge aclk) disable iff (!rst_n)
        m_awvalid |-> m_awaddr[ALIGN_BITS-1:0] == '0)
    else begin
        err_seen = 1'b1;
        $error("m_awaddr has low address bits set");
    end

endmodule

// File: sim/tb_axi4_write_width_convert.sv
/*
  Testbench for the write width converter. Random bursts of 1 to 16 beats
  in two phases, endian 0 then endian 1, with random idles on both sides.
  Expected commands and words are queued as they are sent.
*/

`timescale 1ns/1ps

module tb_axi4_write_width_convert import wwc_pkg::*; ();

    localparam int          BURSTS      = 40;
    localparam int          MAX_BEATS   = 16;
    localparam int          WATCHDOG_NS = 2 * BURSTS * MAX_BEATS * 8 * 40 + 20000;
    localparam logic [31:0] SEED        = 32'hcb89ee9a;

    logic                aclk;
    logic                rst_n;
    logic                endian;
    logic [ADDR_W-1:0]   s_awaddr;
    len_t                s_awlen;
    logic                s_awvalid;
    logic                s_awready;
    logic [ADDR_W-1:0]   m_awaddr;
    len_t                m_awlen;
    logic                m_awvalid;
    logic                m_awready;
    s_word_t             s_wdata;
    logic                s_wlast;
    logic                s_wvalid;
    logic                s_wready;
    logic [M_DATA_W-1:0] m_wdata;
    logic [M_STRB_W-1:0] m_wstrb;
    logic                m_wlast;
    logic                m_wvalid;
    logic                m_wready;

    // reference queues, filled by the drivers
    logic [ADDR_W-1:0]   exp_addr [$];
    len_t                exp_len [$];
    logic [M_DATA_W-1:0] exp_data [$];
    logic [M_STRB_W-1:0] exp_strb [$];
    logic                exp_last [$];

    int                  burst_beats [BURSTS];
    logic [ADDR_W-1:0]   burst_addr [BURSTS];
    logic [31:0]         rng_main;
    logic [31:0]         rng_cmd;
    logic [31:0]         rng_dat;
    logic [31:0]         rng_rdy;

    axi4_write_width_convert u_dut (.*);

    bind axi4_write_width_convert wwc_props u_props (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .s_awready (s_awready),
        .s_wready  (s_wready),
        .m_awaddr  (m_awaddr),
        .m_awlen   (m_awlen),
        .m_awvalid (m_awvalid),
        .m_awready (m_awready),
        .m_wdata   (m_wdata),
        .m_wstrb   (m_wstrb),
        .m_wlast   (m_wlast),
        .m_wvalid  (m_wvalid),
        .m_wready  (m_wready)
    );

    // ----------------------------------------------------------
    // helpers
    // ----------------------------------------------------------

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    // earlier beat goes to lane endian, a half word has one lane of strobes
    function automatic void push_word(input s_word_t early, input s_word_t late,
                                      input logic full, input logic last);
        logic [M_DATA_W-1:0] word;
        logic [M_STRB_W-1:0] strb;
        if (endian == 1'b0) begin
            word = {late, early};
            strb = full ? 8'hff : 8'h0f;
        end else begin
            word = {early, late};
            strb = full ? 8'hff : 8'hf0;
        end
        exp_data.push_back(word);
        exp_strb.push_back(strb);
        exp_last.push_back(last);
    endfunction

    task automatic plan_bursts();
        logic [31:0] r;
        for (int i = 0; i < BURSTS; i++) begin
            rng_main = xorshift(rng_main);
            r = rng_main;
            burst_beats[i] = 1 + int'(r[3:0]);
            // now and then keep stray low address bits
            burst_addr[i] = (r[7:6] == 2'b00) ? r : {r[31:3], 3'b000};
        end
    endtask

    task automatic send_cmds();
        logic [31:0] r;
        for (int i = 0; i < BURSTS; i++) begin
            rng_cmd = xorshift(rng_cmd);
            r = rng_cmd;
            if (r[1:0] == 2'b00) begin
                s_awvalid <= 1'b0;
                repeat (int'(r[4:2]) + 1) @(posedge aclk);
            end
            s_awvalid <= 1'b1;
            s_awaddr  <= burst_addr[i];
            s_awlen   <= len_t'(burst_beats[i] - 1);
            @(posedge aclk);
            while (!s_awready) @(posedge aclk);
            exp_addr.push_back(burst_addr[i] & ~32'h7);
            exp_len.push_back(len_t'((burst_beats[i] - 1) >> 1));
        end
        s_awvalid <= 1'b0;
    endtask

    task automatic send_data();
        logic [31:0] r;
        s_word_t     d;
        s_word_t     first;
        int          n;
        for (int i = 0; i < BURSTS; i++) begin
            n = burst_beats[i];
            for (int j = 0; j < n; j++) begin
                rng_dat = xorshift(rng_dat);
                r = rng_dat;
                rng_dat = xorshift(rng_dat);
                d = rng_dat;
                if (r[1:0] == 2'b00) begin
                    s_wvalid <= 1'b0;
                    repeat (int'(r[3:2]) + 1) @(posedge aclk);
                end
                s_wvalid <= 1'b1;
                s_wdata  <= d;
                s_wlast  <= (j == n - 1);
                @(posedge aclk);
                while (!s_wready) @(posedge aclk);
                if (j % 2 == 0) begin
                    first = d;
                    if (j == n - 1) begin
                        push_word(d, '0, 1'b0, 1'b1);
                    end
                end else begin
                    push_word(first, d, 1'b1, j == n - 1);
                end
            end
        end
        s_wvalid <= 1'b0;
        s_wlast  <= 1'b0;
    endtask

    // endian only moves once both sides are idle
    task automatic run_phase(input logic e);
        endian <= e;
        @(posedge aclk);
        plan_bursts();
        fork
            send_cmds();
            send_data();
        join
        while (exp_addr.size() != 0 || exp_data.size() != 0) begin
            @(posedge aclk);
        end
        repeat (2) @(posedge aclk);
    endtask

    // ----------------------------------------------------------
    // clock, ready and watchdog
    // ----------------------------------------------------------

    initial begin
        aclk = 1'b0;
        forever #20 aclk = ~aclk;
    end

    always @(posedge aclk) begin
        rng_rdy = xorshift(rng_rdy);
        m_awready <= rng_rdy[0] | rng_rdy[1];
        m_wready  <= rng_rdy[2] | rng_rdy[3];
    end

    initial begin
        #(WATCHDOG_NS);
        stop_on_error("timeout: the bursts did not drain within the expected run time");
    end

    // ----------------------------------------------------------
    // checks
    // ----------------------------------------------------------

    always @(posedge aclk) begin
        if (u_dut.u_props.err_seen) begin
            stop_on_error("a bound handshake, alignment or reset property failed");
        end
    end

    always @(posedge aclk) begin
        if (rst_n && m_awvalid && m_awready) begin
            if (exp_addr.size() == 0) begin
                stop_on_error("m_aw transfer with no command outstanding");
            end else begin
                assert (m_awaddr == exp_addr[0] && m_awlen == exp_len[0]) begin
                    void'(exp_addr.pop_front());
                    void'(exp_len.pop_front());
                end else begin
                    stop_on_error($sformatf("Error at %0t ns: m_aw %h len %0d, expected %h len %0d",
                        $time, m_awaddr, m_awlen, exp_addr[0], exp_len[0]));
                end
            end
        end
    end

    always @(posedge aclk) begin
        if (rst_n && m_wvalid && m_wready) begin
            if (exp_data.size() == 0) begin
                stop_on_error("m_w transfer with no word outstanding");
            end else begin
                assert (m_wdata == exp_data[0] && m_wstrb == exp_strb[0]
                        && m_wlast == exp_last[0]) begin
                    void'(exp_data.pop_front());
                    void'(exp_strb.pop_front());
                    void'(exp_last.pop_front());
                end else begin
                    stop_on_error($sformatf("Error at %0t ns: m_w %h %h %b, expected %h %h %b",
                        $time, m_wdata, m_wstrb, m_wlast, exp_data[0], exp_strb[0],
                        exp_last[0]));
                end
            end
        end
    end

    // ----------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------

    initial begin
        rst_n     = 1'b0;
        endian    = 1'b0;
        s_awaddr  = '0;
        s_awlen   = '0;
        s_awvalid = 1'b0;
        m_awready = 1'b0;
        s_wdata   = '0;
        s_wlast   = 1'b0;
        s_wvalid  = 1'b0;
        m_wready  = 1'b0;
        rng_main  = SEED;
        rng_cmd   = SEED ^ 32'h9e3779b9;
        rng_dat   = SEED ^ 32'h7f4a7c15;
        rng_rdy   = SEED ^ 32'h2545f491;
        repeat (10) @(posedge aclk);
        rst_n <= 1'b1;
        repeat (2) @(posedge aclk);
        run_phase(1'b0);
        run_phase(1'b1);
        if (exp_addr.size() != 0 || exp_data.size() != 0) begin
            stop_on_error("expected transfers were still outstanding at the end");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

// File: list.f
common/wwc_pkg.sv
gate/burst_fifo.sv
gate/w_burst_gate.sv
wpack/w_pack.sv
hdl/aw_convert.sv
hdl/axi4_write_width_convert.sv
sim/wwc_props.sv
sim/tb_axi4_write_width_convert.sv

// File: Makefile
# Verilator build and run of the write width converter testbench

VERILATOR ?= verilator
TOP       ?= tb_axi4_write_width_convert
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing -j 0
RUN_ARGS  ?= +verilator+error+limit+100

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS RUN_ARGS"

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	-./$(SIM) $(RUN_ARGS) > $(LOG) 2>&1
	@grep -q "TESTBENCH PASSED" $(LOG) && echo "test passed" || \
		(echo "test failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
